//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb -Mdir "$OBJ" -o tb_sim -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "test passed" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0

//--- source/axil_decode.sv
/* Address decoder for the chip register space. Steers each request to the
   pad controller or the mailbox by one address bit and answers unmapped
   offsets itself with DECERR. One transaction in flight per direction */
`timescale 1ns/1ps
`default_nettype none

`include "chip_params.svh"

module axil_decode (
  input  logic clk_i,
  input  logic rst_i,
  axil_if.slv  up,
  axil_if.mst  pad,
  axil_if.mst  mbx
);

  logic wr_busy, wr_req, wr_mapped, wr_to_mbx, err_wr_acc;
  logic rd_busy, rd_req, rd_mapped, rd_to_mbx, err_rd_acc;
  logic err_bvalid_q, err_rvalid_q;

  function automatic logic is_mapped(input logic [`CHIP_ADDR_W-1:0] addr);
    case (addr)
      `PAD_GPIO_OUT, `PAD_GPIO_OE, `PAD_GPIO_IN, `PAD_STRAPS,
      `MBX_STATUS, `MBX_LOG: is_mapped = 1'b1;
      default:               is_mapped = 1'b0;
    endcase
  endfunction

  // Write side, held off while any response is still pending
  assign wr_busy    = err_bvalid_q | pad.bvalid | mbx.bvalid;
  assign wr_req     = up.awvalid & up.wvalid & ~wr_busy;
  assign wr_mapped  = is_mapped(up.awaddr);
  assign wr_to_mbx  = up.awaddr[`CHIP_MBX_SEL_BIT];
  assign err_wr_acc = wr_req & ~wr_mapped;

  assign pad.awvalid = wr_req & wr_mapped & ~wr_to_mbx;
  assign pad.wvalid  = wr_req & wr_mapped & ~wr_to_mbx;
  assign mbx.awvalid = wr_req & wr_mapped & wr_to_mbx;
  assign mbx.wvalid  = wr_req & wr_mapped & wr_to_mbx;
  assign pad.awaddr  = up.awaddr;
  assign mbx.awaddr  = up.awaddr;
  assign pad.wdata   = up.wdata;
  assign mbx.wdata   = up.wdata;
  assign pad.wstrb   = up.wstrb;
  assign mbx.wstrb   = up.wstrb;
  assign pad.bready  = up.bready;
  assign mbx.bready  = up.bready;

  // Only the selected slave can be ready
  assign up.awready = err_wr_acc | pad.awready | mbx.awready;
  assign up.wready  = err_wr_acc | pad.wready | mbx.wready;
  assign up.bvalid  = wr_busy;
  assign up.bresp   = err_bvalid_q ? chip_pkg::DECERR : (pad.bvalid ? pad.bresp : mbx.bresp);

  // Read side
  assign rd_busy    = err_rvalid_q | pad.rvalid | mbx.rvalid;
  assign rd_req     = up.arvalid & ~rd_busy;
  assign rd_mapped  = is_mapped(up.araddr);
  assign rd_to_mbx  = up.araddr[`CHIP_MBX_SEL_BIT];
  assign err_rd_acc = rd_req & ~rd_mapped;

  assign pad.arvalid = rd_req & rd_mapped & ~rd_to_mbx;
  assign mbx.arvalid = rd_req & rd_mapped & rd_to_mbx;
  assign pad.araddr  = up.araddr;
  assign mbx.araddr  = up.araddr;
  assign pad.rready  = up.rready;
  assign mbx.rready  = up.rready;

  assign up.arready = err_rd_acc | pad.arready | mbx.arready;
  assign up.rvalid  = rd_busy;
  assign up.rdata   = err_rvalid_q ? '0 : (pad.rvalid ? pad.rdata : mbx.rdata);
  assign up.rresp   = err_rvalid_q ? chip_pkg::DECERR : (pad.rvalid ? pad.rresp : mbx.rresp);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_bvalid_q <= 1'b0;
      err_rvalid_q <= 1'b0;
    end else begin
      if (err_wr_acc) err_bvalid_q <= 1'b1;
      else if (up.bready) err_bvalid_q <= 1'b0;
      if (err_rd_acc) err_rvalid_q <= 1'b1;
      else if (up.rready) err_rvalid_q <= 1'b0;
    end
  end

  // Local error response never overlaps a slave response
  a_single_bresp: assert property (@(posedge clk_i) disable iff (rst_i)
    !(err_bvalid_q && (pad.bvalid || mbx.bvalid)));

endmodule

`default_nettype wire

//--- source/axil_if.sv
/* AXI4-Lite bus between the decoder and the register slaves.
   mst drives requests and response ready, slv the opposite side */
`timescale 1ns/1ps
`default_nettype none

`include "chip_params.svh"

interface axil_if;
  logic                    awvalid, awready;
  logic [`CHIP_ADDR_W-1:0] awaddr;
  logic                    wvalid, wready;
  logic [`CHIP_DATA_W-1:0] wdata;
  logic [`CHIP_STRB_W-1:0] wstrb;
  logic                    bvalid, bready;
  logic [1:0]              bresp;
  logic                    arvalid, arready;
  logic [`CHIP_ADDR_W-1:0] araddr;
  logic                    rvalid, rready;
  logic [`CHIP_DATA_W-1:0] rdata;
  logic [1:0]              rresp;

  modport mst (output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
               input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp);

  modport slv (input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
               output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp);
endinterface

`default_nettype wire

//--- source/chip_core.sv
/* Chip subsystem top level. Plain AXI4-Lite slave ports feed the decoder,
   which serves the pad controller and the software status mailbox */
`timescale 1ns/1ps
`default_nettype none

`include "chip_params.svh"

module chip_core (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  input  logic [`CHIP_ADDR_W-1:0]   s_awaddr_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  input  logic [`CHIP_DATA_W-1:0]   s_wdata_i,
  input  logic [`CHIP_STRB_W-1:0]   s_wstrb_i,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  output chip_pkg::axil_resp_e      s_bresp_o,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  input  logic [`CHIP_ADDR_W-1:0]   s_araddr_i,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  output logic [`CHIP_DATA_W-1:0]   s_rdata_o,
  output chip_pkg::axil_resp_e      s_rresp_o,
  input  logic [`CHIP_NUM_GPIO-1:0] gpio_i,
  output logic [`CHIP_NUM_GPIO-1:0] gpio_o,
  output logic [`CHIP_NUM_GPIO-1:0] gpio_oe_o,
  input  logic [2:0]                sw_straps_i,
  input  logic [1:0]                tap_straps_i,
  input  logic [1:0]                dft_straps_i,
  output logic                      test_done_o,
  output logic                      test_pass_o,
  output logic                      log_valid_o,
  output logic [7:0]                log_char_o
);

  axil_if up_bus ();
  axil_if pad_bus ();
  axil_if mbx_bus ();

  assign up_bus.awvalid = s_awvalid_i;
  assign up_bus.awaddr  = s_awaddr_i;
  assign up_bus.wvalid  = s_wvalid_i;
  assign up_bus.wdata   = s_wdata_i;
  assign up_bus.wstrb   = s_wstrb_i;
  assign up_bus.bready  = s_bready_i;
  assign up_bus.arvalid = s_arvalid_i;
  assign up_bus.araddr  = s_araddr_i;
  assign up_bus.rready  = s_rready_i;
  assign s_awready_o    = up_bus.awready;
  assign s_wready_o     = up_bus.wready;
  assign s_bvalid_o     = up_bus.bvalid;
  assign s_bresp_o      = chip_pkg::axil_resp_e'(up_bus.bresp);
  assign s_arready_o    = up_bus.arready;
  assign s_rvalid_o     = up_bus.rvalid;
  assign s_rdata_o      = up_bus.rdata;
  assign s_rresp_o      = chip_pkg::axil_resp_e'(up_bus.rresp);

  axil_decode axil_decode_inst (.clk_i, .rst_i, .up(up_bus), .pad(pad_bus), .mbx(mbx_bus));

  pad_ctrl pad_ctrl_inst (
    .clk_i, .rst_i, .bus(pad_bus),
    .gpio_i, .gpio_o, .gpio_oe_o,
    .sw_straps_i, .tap_straps_i, .dft_straps_i
  );

  sw_status_mbx sw_status_mbx_inst (
    .clk_i, .rst_i, .bus(mbx_bus),
    .test_done_o, .test_pass_o, .log_valid_o, .log_char_o
  );

endmodule

`default_nettype wire

//--- source/chip_params.svh
/* Bus widths, register map and pad counts for the chip subsystem.
   Include at the top of any file that needs a width or an offset */
`ifndef CHIP_PARAMS_SVH
`define CHIP_PARAMS_SVH

`define CHIP_ADDR_W      12
`define CHIP_DATA_W      32
`define CHIP_STRB_W      (`CHIP_DATA_W / 8)
`define CHIP_NUM_GPIO    16

// Pad controller registers
`define PAD_GPIO_OUT     12'h000
`define PAD_GPIO_OE      12'h004
`define PAD_GPIO_IN      12'h008   // Read only
`define PAD_STRAPS       12'h00C   // Read only

// Software status mailbox
`define MBX_STATUS       12'h100
`define MBX_LOG          12'h104

// Address bit that steers a request to the mailbox
`define CHIP_MBX_SEL_BIT 8

`endif

//--- source/chip_pkg.sv
/* Types shared by the chip subsystem and its testbench.
   Use by scoped name, e.g. chip_pkg::DECERR */
`default_nettype none

`include "chip_params.svh"

package chip_pkg;

  // AXI4-Lite response codes in use
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    DECERR = 2'd3
  } axil_resp_e;

  // Codes software writes to the status word
  typedef enum logic [15:0] {
    BOOT    = 16'h0000,
    IN_TEST = 16'h4354,
    PASSED  = 16'h900D,
    FAILED  = 16'hBAAD
  } sw_status_e;

  // Byte-strobe merge of the low half of a bus word into a 16-bit register
  function automatic logic [15:0] merge_lo16(
    input logic [15:0]               old_val,
    input logic [`CHIP_DATA_W-1:0]   wdata,
    input logic [`CHIP_STRB_W-1:0]   strb
  );
    logic [15:0] res;
    res = old_val;
    for (int i = 0; i < 2; i++) begin
      if (strb[i]) res[i*8 +: 8] = wdata[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- source/pad_ctrl.sv
/* GPIO pad controller. Output and output-enable registers with byte strobes,
   a two-flop input synchroniser, and strap pins latched once after reset */
`timescale 1ns/1ps
`default_nettype none

`include "chip_params.svh"

module pad_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  axil_if.slv                      bus,
  input  logic [`CHIP_NUM_GPIO-1:0] gpio_i,
  output logic [`CHIP_NUM_GPIO-1:0] gpio_o,
  output logic [`CHIP_NUM_GPIO-1:0] gpio_oe_o,
  input  logic [2:0]               sw_straps_i,
  input  logic [1:0]               tap_straps_i,
  input  logic [1:0]               dft_straps_i
);

  logic [`CHIP_NUM_GPIO-1:0] gpio_out_q, gpio_oe_q;
  logic [`CHIP_NUM_GPIO-1:0] sync_q1, sync_q2;
  logic [6:0]                straps_q;
  logic                      straps_done_q;
  logic                      bvalid_q, rvalid_q;
  logic [`CHIP_DATA_W-1:0]   rdata_q, rd_word;
  logic                      wr_acc, rd_acc;

  assign wr_acc      = bus.awvalid & bus.wvalid & ~bvalid_q;
  assign rd_acc      = bus.arvalid & ~rvalid_q;
  assign bus.awready = wr_acc;
  assign bus.wready  = wr_acc;
  assign bus.arready = rd_acc;
  assign bus.bvalid  = bvalid_q;
  assign bus.bresp   = chip_pkg::OKAY;   // GPIO_IN and STRAPS ignore writes
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = chip_pkg::OKAY;

  assign gpio_o    = gpio_out_q;
  assign gpio_oe_o = gpio_oe_q;

  always_comb begin
    case (bus.araddr)
      `PAD_GPIO_OUT: rd_word = {{(`CHIP_DATA_W-`CHIP_NUM_GPIO){1'b0}}, gpio_out_q};
      `PAD_GPIO_OE:  rd_word = {{(`CHIP_DATA_W-`CHIP_NUM_GPIO){1'b0}}, gpio_oe_q};
      `PAD_GPIO_IN:  rd_word = {{(`CHIP_DATA_W-`CHIP_NUM_GPIO){1'b0}}, sync_q2};
      `PAD_STRAPS:   rd_word = {{(`CHIP_DATA_W-7){1'b0}}, straps_q};
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_out_q    <= '0;
      gpio_oe_q     <= '0;
      bvalid_q      <= 1'b0;
      rvalid_q      <= 1'b0;
      straps_done_q <= 1'b0;
    end else begin
      if (wr_acc && bus.awaddr == `PAD_GPIO_OUT)
        gpio_out_q <= chip_pkg::merge_lo16(gpio_out_q, bus.wdata, bus.wstrb);
      if (wr_acc && bus.awaddr == `PAD_GPIO_OE)
        gpio_oe_q <= chip_pkg::merge_lo16(gpio_oe_q, bus.wdata, bus.wstrb);
      if (wr_acc) bvalid_q <= 1'b1;
      else if (bus.bready) bvalid_q <= 1'b0;
      if (rd_acc) rvalid_q <= 1'b1;
      else if (bus.rready) rvalid_q <= 1'b0;
      if (!straps_done_q) straps_done_q <= 1'b1;   // First cycle out of reset only
    end
  end

  always_ff @(posedge clk_i) begin
    sync_q1 <= gpio_i;
    sync_q2 <= sync_q1;
    if (rd_acc) rdata_q <= rd_word;
    if (!rst_i && !straps_done_q) straps_q <= {dft_straps_i, tap_straps_i, sw_straps_i};
  end

  // Write response is held until taken
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    bus.bvalid && !bus.bready |=> bus.bvalid);

endmodule

`default_nettype wire

//--- source/sw_status_mbx.sv
/* Software status mailbox. A write to the status word sets test-done and
   test-pass, a write to the log word emits its low byte as a one-cycle pulse */
`timescale 1ns/1ps
`default_nettype none

`include "chip_params.svh"

module sw_status_mbx (
  input  logic       clk_i,
  input  logic       rst_i,
  axil_if.slv        bus,
  output logic       test_done_o,
  output logic       test_pass_o,
  output logic       log_valid_o,
  output logic [7:0] log_char_o
);

  chip_pkg::sw_status_e    status_q, status_d;
  logic                    done_q, pass_q, log_valid_q;
  logic [7:0]              log_char_q;
  logic                    bvalid_q, rvalid_q;
  logic [`CHIP_DATA_W-1:0] rdata_q;
  logic                    wr_acc, rd_acc;

  assign wr_acc      = bus.awvalid & bus.wvalid & ~bvalid_q;
  assign rd_acc      = bus.arvalid & ~rvalid_q;
  assign bus.awready = wr_acc;
  assign bus.wready  = wr_acc;
  assign bus.arready = rd_acc;
  assign bus.bvalid  = bvalid_q;
  assign bus.bresp   = chip_pkg::OKAY;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = chip_pkg::OKAY;

  assign test_done_o = done_q;
  assign test_pass_o = pass_q;
  assign log_valid_o = log_valid_q;
  assign log_char_o  = log_char_q;

  // Strobed bytes of the incoming code
  assign status_d = chip_pkg::sw_status_e'(chip_pkg::merge_lo16(status_q, bus.wdata, bus.wstrb));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      status_q    <= chip_pkg::BOOT;
      done_q      <= 1'b0;
      pass_q      <= 1'b0;
      log_valid_q <= 1'b0;
      bvalid_q    <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      if (wr_acc && bus.awaddr == `MBX_STATUS) begin
        status_q <= status_d;
        done_q   <= (status_d == chip_pkg::PASSED) || (status_d == chip_pkg::FAILED);
        pass_q   <= (status_d == chip_pkg::PASSED);
      end
      log_valid_q <= wr_acc && bus.awaddr == `MBX_LOG;   // Single-cycle pulse
      if (wr_acc) bvalid_q <= 1'b1;
      else if (bus.bready) bvalid_q <= 1'b0;
      if (rd_acc) rvalid_q <= 1'b1;
      else if (bus.rready) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc && bus.awaddr == `MBX_LOG) log_char_q <= bus.wdata[7:0];
    if (rd_acc) begin
      // Log word reads as zero
      rdata_q <= (bus.araddr == `MBX_STATUS) ? {{(`CHIP_DATA_W-16){1'b0}}, status_q} : '0;
    end
  end

  // Read data is held until taken
  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    bus.rvalid && !bus.rready |=> bus.rvalid);

endmodule

`default_nettype wire

//--- test/tb.sv
/* Chip-level testbench for chip_core. Plays the AXI4-Lite host, drives pads and
   straps, and applies a table of bus and pin checks built at time zero */
`timescale 1ns/1ps
`default_nettype none

`include "chip_params.svh"

module tb;

  typedef enum logic [2:0] {K_WR, K_RD, K_PIN, K_FLAG, K_LOG, K_GIN, K_GLAT} kind_e;

  typedef struct packed {
    kind_e                   kind;
    logic [`CHIP_ADDR_W-1:0] addr;
    logic [`CHIP_DATA_W-1:0] data;
    logic [`CHIP_STRB_W-1:0] strb;
    logic [`CHIP_DATA_W-1:0] exp_data;
    chip_pkg::axil_resp_e    exp_resp;
  } entry_t;

  logic                      clk, rst_i;
  logic                      s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
  logic                      s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o;
  logic                      s_rvalid_o, s_rready_i;
  logic [`CHIP_ADDR_W-1:0]   s_awaddr_i, s_araddr_i;
  logic [`CHIP_DATA_W-1:0]   s_wdata_i, s_rdata_o;
  logic [`CHIP_STRB_W-1:0]   s_wstrb_i;
  chip_pkg::axil_resp_e      s_bresp_o, s_rresp_o;
  logic [`CHIP_NUM_GPIO-1:0] gpio_i, gpio_o, gpio_oe_o;
  logic [2:0]                sw_straps_i;
  logic [1:0]                tap_straps_i, dft_straps_i;
  logic                      test_done_o, test_pass_o, log_valid_o;
  logic [7:0]                log_char_o;

  entry_t      tbl[$];
  logic [31:0] lfsr_q;
  logic [6:0]  straps_set;   // Strap pins as held during reset
  int          err_cnt = 0;
  int          fail_tests = 0;
  int          test_cnt = 0;
  int          log_pulses = 0;
  int          log_writes = 0;

  chip_core chip_core_inst (.clk_i(clk), .*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_i && log_valid_o) log_pulses <= log_pulses + 1;
  end

  // Fibonacci LFSR with taps 32 22 2 1 and one step per returned bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] res;
    logic        fb;
    res = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      res    = {res[30:0], fb};
    end
    return res;
  endfunction

  // Only the two low byte lanes reach a 16-bit pad register
  function automatic logic [15:0] merge_bytes(input logic [15:0] cur, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [15:0] res;
    res = cur;
    if (strb[0]) res[7:0] = data[7:0];
    if (strb[1]) res[15:8] = data[15:8];
    return res;
  endfunction

  task automatic check_data(input string name, input logic [`CHIP_DATA_W-1:0] got,
                            input logic [`CHIP_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input string name, input chip_pkg::axil_resp_e got,
                            input chip_pkg::axil_resp_e exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %s (%0d), expected %s (%0d)", $time, name,
               got.name(), got, exp.name(), exp);
      err_cnt++;
    end
  endtask

  task automatic check_status(input string name, input chip_pkg::sw_status_e got,
                              input chip_pkg::sw_status_e exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is 0x%04h, expected 0x%04h (%s)", $time, name,
               got, exp, exp.name());
      err_cnt++;
    end
  endtask

  // b and r ready stay high, so bvalid seen at a falling edge means aw and w were taken
  task automatic axil_write(input logic [`CHIP_ADDR_W-1:0] addr,
                            input logic [`CHIP_DATA_W-1:0] data,
                            input logic [`CHIP_STRB_W-1:0] strb,
                            output chip_pkg::axil_resp_e resp);
    int n;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!s_bvalid_o && n < 50) begin
      @(negedge clk);
      n++;
    end
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    resp = s_bresp_o;
    if (!s_bvalid_o) begin
      $display("Timeout: no write response within 50 cycles for address 0x%03h", addr);
      err_cnt++;
    end
  endtask

  task automatic axil_read(input logic [`CHIP_ADDR_W-1:0] addr,
                           output logic [`CHIP_DATA_W-1:0] data,
                           output chip_pkg::axil_resp_e resp);
    int n;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    n = 0;
    @(negedge clk);
    while (!s_rvalid_o && n < 50) begin
      @(negedge clk);
      n++;
    end
    s_arvalid_i = 1'b0;
    data = s_rdata_o;
    resp = s_rresp_o;
    if (!s_rvalid_o) begin
      $display("Timeout: no read data within 50 cycles for address 0x%03h", addr);
      err_cnt++;
    end
  endtask

  task automatic add_entry(input kind_e kind, input logic [`CHIP_ADDR_W-1:0] addr,
                           input logic [31:0] data, input logic [`CHIP_STRB_W-1:0] strb,
                           input logic [31:0] exp_data, input chip_pkg::axil_resp_e exp_resp);
    entry_t e;
    e.kind     = kind;
    e.addr     = addr;
    e.data     = data;
    e.strb     = strb;
    e.exp_data = exp_data;
    e.exp_resp = exp_resp;
    tbl.push_back(e);
  endtask

  task automatic report_test(input string what, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("%s ... ok", what);
    end else begin
      $display("%s ... FAIL", what);
      fail_tests++;
    end
  endtask

  task automatic build_table();
    logic [15:0]             exp_out, exp_oe, gin;
    logic [31:0]             d;
    logic [`CHIP_STRB_W-1:0] s;
    logic [`CHIP_ADDR_W-1:0] bad [3];
    chip_pkg::sw_status_e    codes [3];
    logic [1:0]              flags [3];   // Expected {done, pass} per code
    string                   msg;
    exp_out = '0;
    exp_oe  = '0;
    gin     = '0;
    msg     = "boot";
    bad     = '{12'h010, 12'h108, 12'h300};
    codes   = '{chip_pkg::IN_TEST, chip_pkg::FAILED, chip_pkg::PASSED};
    flags   = '{2'b00, 2'b10, 2'b11};
    add_entry(K_RD, `PAD_GPIO_OUT, 0, 4'h0, 0, chip_pkg::OKAY);
    add_entry(K_RD, `PAD_GPIO_OE, 0, 4'h0, 0, chip_pkg::OKAY);
    add_entry(K_RD, `PAD_STRAPS, 0, 4'h0, {25'd0, straps_set}, chip_pkg::OKAY);
    for (int i = 0; i < 5; i++) begin
      d = lfsr_bits(32);
      if (i == 0) s = 4'hF;
      else s = 4'(lfsr_bits(4));   // Partial strobes after the first pass
      exp_out = merge_bytes(exp_out, d, s);
      add_entry(K_WR, `PAD_GPIO_OUT, d, s, 0, chip_pkg::OKAY);
      add_entry(K_PIN, 12'h0, 0, 4'h0, {exp_oe, exp_out}, chip_pkg::OKAY);
      d = lfsr_bits(32);
      if (i == 0) s = 4'hF;
      else s = 4'(lfsr_bits(4));
      exp_oe = merge_bytes(exp_oe, d, s);
      add_entry(K_WR, `PAD_GPIO_OE, d, s, 0, chip_pkg::OKAY);
      add_entry(K_PIN, 12'h0, 0, 4'h0, {exp_oe, exp_out}, chip_pkg::OKAY);
      add_entry(K_RD, `PAD_GPIO_OUT, 0, 4'h0, {16'd0, exp_out}, chip_pkg::OKAY);
      add_entry(K_RD, `PAD_GPIO_OE, 0, 4'h0, {16'd0, exp_oe}, chip_pkg::OKAY);
    end
    for (int i = 0; i < 3; i++) begin
      d   = lfsr_bits(16);
      gin = d[15:0];
      add_entry(K_GIN, `PAD_GPIO_IN, d, 4'h0, {16'd0, gin}, chip_pkg::OKAY);
    end
    add_entry(K_GLAT, `PAD_GPIO_IN, {16'd0, ~gin}, 4'h0, 0, chip_pkg::OKAY);
    foreach (codes[i]) begin
      add_entry(K_WR, `MBX_STATUS, {16'd0, codes[i]}, 4'hF, 0, chip_pkg::OKAY);
      add_entry(K_FLAG, 12'h0, 0, 4'h0, {30'd0, flags[i]}, chip_pkg::OKAY);
      add_entry(K_RD, `MBX_STATUS, 0, 4'h0, {16'd0, codes[i]}, chip_pkg::OKAY);
    end
    for (int i = 0; i < msg.len(); i++) begin
      add_entry(K_LOG, `MBX_LOG, {24'd0, msg[i]}, 4'hF, {24'd0, msg[i]}, chip_pkg::OKAY);
    end
    add_entry(K_RD, `MBX_LOG, 0, 4'h0, 0, chip_pkg::OKAY);   // Log word reads as zero
    foreach (bad[i]) begin
      add_entry(K_WR, bad[i], 32'hFFFF_FFFF, 4'hF, 0, chip_pkg::DECERR);
      add_entry(K_RD, bad[i], 0, 4'h0, 0, chip_pkg::DECERR);
    end
    add_entry(K_WR, `PAD_GPIO_IN, {16'd0, ~gin}, 4'hF, 0, chip_pkg::OKAY);
    add_entry(K_RD, `PAD_GPIO_IN, 0, 4'h0, {16'd0, gin}, chip_pkg::OKAY);
  endtask

  task automatic run_entry(input int idx, input entry_t e);
    chip_pkg::axil_resp_e      resp;
    logic [`CHIP_DATA_W-1:0]   rdata;
    logic [`CHIP_NUM_GPIO-1:0] old_in;
    int                        errs;
    int                        n;
    errs = err_cnt;
    case (e.kind)
      K_WR: begin
        axil_write(e.addr, e.data, e.strb, resp);
        check_resp("s_bresp_o", resp, e.exp_resp);
      end
      K_RD: begin
        axil_read(e.addr, rdata, resp);
        check_resp("s_rresp_o", resp, e.exp_resp);
        if (e.addr == `MBX_STATUS)
          check_status("s_rdata_o[15:0]", chip_pkg::sw_status_e'(rdata[15:0]),
                       chip_pkg::sw_status_e'(e.exp_data[15:0]));
        else
          check_data("s_rdata_o", rdata, e.exp_data);
      end
      K_PIN: check_data("{gpio_oe_o, gpio_o}", {gpio_oe_o, gpio_o}, e.exp_data);
      K_FLAG: check_data("{test_done_o, test_pass_o}", {30'd0, test_done_o, test_pass_o},
                         e.exp_data);
      K_LOG: begin
        axil_write(e.addr, e.data, e.strb, resp);
        log_writes++;
        check_resp("s_bresp_o", resp, e.exp_resp);
        check_data("log_valid_o", {31'd0, log_valid_o}, 32'd1);
        check_data("log_char_o", {24'd0, log_char_o}, e.exp_data);
        @(negedge clk);
        check_data("log_valid_o", {31'd0, log_valid_o}, 32'd0);   // Single cycle wide
      end
      K_GIN: begin
        gpio_i = e.data[15:0];
        n = 0;
        axil_read(`PAD_GPIO_IN, rdata, resp);
        while (rdata !== e.exp_data && n < 50) begin
          axil_read(`PAD_GPIO_IN, rdata, resp);
          n++;
        end
        if (rdata !== e.exp_data) begin
          $display("GPIO_IN did not follow gpio_i within 50 reads");
          err_cnt++;
        end
        check_resp("s_rresp_o", resp, e.exp_resp);
      end
      K_GLAT: begin
        old_in = gpio_i;
        gpio_i = e.data[15:0];
        @(negedge clk);
        axil_read(`PAD_GPIO_IN, rdata, resp);   // Sampled before the synchroniser catches up
        check_data("s_rdata_o", rdata, {16'd0, old_in});
        gpio_i = ~e.data[15:0];
        repeat (2) @(negedge clk);
        axil_read(`PAD_GPIO_IN, rdata, resp);
        check_data("s_rdata_o", rdata, {16'd0, ~e.data[15:0]});
      end
      default: ;
    endcase
    report_test($sformatf("entry %0d %s addr 0x%03h", idx, e.kind.name(), e.addr), errs);
  endtask

  initial begin
    int errs;
    lfsr_q      = 32'd97294;
    rst_i       = 1'b1;
    s_awvalid_i = 1'b0;
    s_awaddr_i  = '0;
    s_wvalid_i  = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_bready_i  = 1'b1;
    s_arvalid_i = 1'b0;
    s_araddr_i  = '0;
    s_rready_i  = 1'b1;
    gpio_i      = '0;
    straps_set  = 7'(lfsr_bits(7));
    {dft_straps_i, tap_straps_i, sw_straps_i} = straps_set;
    build_table();
    repeat (16) @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);
    errs = err_cnt;
    check_data("{awready, wready, arready, bvalid, rvalid}",
               {27'd0, s_awready_o, s_wready_o, s_arready_o, s_bvalid_o, s_rvalid_o}, 0);
    check_data("{gpio_oe_o, gpio_o}", {gpio_oe_o, gpio_o}, 0);
    check_data("{test_done_o, test_pass_o, log_valid_o}",
               {29'd0, test_done_o, test_pass_o, log_valid_o}, 0);
    report_test("reset state", errs);
    {dft_straps_i, tap_straps_i, sw_straps_i} = ~straps_set;   // Latch must ignore this
    foreach (tbl[i]) run_entry(i, tbl[i]);
    errs = err_cnt;
    check_data("log_valid_o pulse count", log_pulses, log_writes);
    report_test("log pulse count", errs);
    $display("%0d tests run, %0d with errors, %0d check errors", test_cnt, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/chip_pkg.sv
source/axil_if.sv
source/axil_decode.sv
source/pad_ctrl.sv
source/sw_status_mbx.sv
source/chip_core.sv
test/tb.sv
